// ==== run.sh ====
#!/bin/sh
# Builds and runs the tower controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module atc_tb -f tb.f -o atc_sim

status=0
./obj_dir/atc_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "tests failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished cleanly"

// ==== tb.f ====
verilog/atc_pkg.sv
verilog/msg_fifo.sv
verilog/id_pool.sv
verilog/runway_locks.sv
verilog/request_sequencer.sv
verilog/reply_sender.sv
verilog/atc_top.sv
testbench/tb_clock_gen.sv
testbench/atc_properties.sv
testbench/atc_tb.sv

// ==== testbench/atc_properties.sv ====
////////////////////////////////////////////////////////////////////////////
// Tower controller port checks
// Reply pulse protocol and runway state after reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module atc_properties import atc_pkg::*; (
  input logic                   clock,
  input logic                   reset,
  input logic                   reply_ready,
  input logic                   reply_send,
  input logic [NUM_RUNWAYS-1:0] runway_active
);

  // One pulse per reply, never two back to back
  send_single_pulse: assert property (
    @(posedge clock) disable iff (reset) reply_send |=> !reply_send
  ) else $error("reply_send stayed high for two cycles");

  // The pop that starts a send happens only with reply_ready high
  send_after_ready: assert property (
    @(posedge clock) disable iff (reset) reply_send |-> $past(reply_ready)
  ) else $error("reply_send without reply_ready in the cycle before");

  runways_free_after_reset: assert property (
    @(posedge clock) reset |=> (runway_active == '0)
  ) else $error("runway still active in the cycle after reset");

endmodule : atc_properties

bind atc_top atc_properties props (
  .clock(clock),
  .reset(reset),
  .reply_ready(reply_ready),
  .reply_send(reply_send),
  .runway_active(runway_active)
);

// ==== testbench/atc_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Tower controller testbench
// Drives request bytes, predicts replies with a reference model and
// compares every reply pulse against it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module atc_tb import atc_pkg::*;;

  localparam int PERIOD_NS       = 100;
  localparam int DRIVE_DELAY     = 10;
  localparam int QUEUE_DEPTH     = 8;
  localparam int MSG_DEPTH       = 4;
  localparam int REQUEST_GAP     = 10;
  localparam int DRAIN_LIMIT     = 200;
  localparam int NUM_MESSAGES    = 50;
  localparam int WATCHDOG_CYCLES = NUM_MESSAGES * 40;
  localparam int READY_LOW       = 0;
  localparam int READY_HIGH      = 1;
  localparam int READY_RANDOM    = 2;

  logic                   clock;
  logic                   reset;
  msg_t                   request_data;
  logic                   request_valid;
  logic                   reply_ready;
  msg_t                   reply_data;
  logic                   reply_send;
  logic [NUM_RUNWAYS-1:0] runway_active;

  // Reference model state
  bit [NUM_IDS-1:0]       model_taken;
  bit [NUM_RUNWAYS-1:0]   model_active;
  plane_id_t              model_owner [NUM_RUNWAYS];
  plane_id_t              takeoff_q [$];
  plane_id_t              landing_q [$];
  bit                     model_takeoff_first;
  msg_t                   expected [$];

  int                     ready_mode;
  bit                     ready_blocked;
  int                     checks;
  int                     errors;

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2), .DRIVE_DELAY(DRIVE_DELAY)) clock_gen (
    .clock(clock),
    .reset(reset)
  );

  atc_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .MSG_DEPTH(MSG_DEPTH)) i_atc_top (
    .clock(clock),
    .reset(reset),
    .request_data(request_data),
    .request_valid(request_valid),
    .reply_ready(reply_ready),
    .reply_data(reply_data),
    .reply_send(reply_send),
    .runway_active(runway_active)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic void push_expected(plane_id_t id, msg_type_t kind, logic action);
    msg_t m;
    m.plane_id   = id;
    m.msg_type   = kind;
    m.msg_action = action;
    expected.push_back(m);
  endfunction

  // One request, then at most one clear onto a free runway
  function automatic void model_message(msg_t m);
    bit        found;
    bit        use_takeoff;
    plane_id_t new_id;
    plane_id_t head;
    int        rw;
    found  = 1'b0;
    new_id = '0;
    case (m.msg_type)
      T_REQUEST: begin
        if (model_taken[m.plane_id]) begin
          if ((m.msg_action ? landing_q.size() : takeoff_q.size()) == QUEUE_DEPTH) begin
            push_expected(m.plane_id, T_DIVERT, 1'b0);
            model_taken[m.plane_id] = 1'b0;
          end else begin
            push_expected(m.plane_id, T_HOLD, 1'b0);
            if (m.msg_action) landing_q.push_back(m.plane_id);
            else takeoff_q.push_back(m.plane_id);
          end
        end
      end
      T_DECLARE: begin
        if (model_taken[m.plane_id] && model_active[m.msg_action] &&
            model_owner[m.msg_action] == m.plane_id) begin
          model_active[m.msg_action] = 1'b0;
          model_taken[m.plane_id]    = 1'b0;
        end
      end
      T_ID_PLEASE: begin
        for (int i = 0; i < NUM_IDS; i++) begin
          if (!found && !model_taken[i]) begin
            new_id = plane_id_t'(i);
            found  = 1'b1;
          end
        end
        if (found) begin
          push_expected(new_id, T_ID_PLEASE, 1'b0);
          model_taken[new_id] = 1'b1;
        end else begin
          push_expected('0, T_ID_PLEASE, 1'b1);
        end
      end
      default: push_expected(m.plane_id, T_SAY_AGAIN, 1'b0);
    endcase
    if (model_active != '1 && (takeoff_q.size() != 0 || landing_q.size() != 0)) begin
      if (takeoff_q.size() != 0 && landing_q.size() != 0) begin
        use_takeoff         = model_takeoff_first;
        model_takeoff_first = !model_takeoff_first;
      end else begin
        use_takeoff = (takeoff_q.size() != 0);
      end
      head = use_takeoff ? takeoff_q.pop_front() : landing_q.pop_front();
      rw   = model_active[0] ? 1 : 0;
      model_active[rw] = 1'b1;
      model_owner[rw]  = head;
      push_expected(head, T_CLEAR, rw[0]);
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clock);
    #(DRIVE_DELAY);
    case (ready_mode)
      READY_LOW:  reply_ready = 1'b0;
      READY_HIGH: reply_ready = 1'b1;
      default:    reply_ready = ($urandom_range(3) != 0);
    endcase
  endtask

  task automatic send_msg(plane_id_t id, msg_type_t kind, logic action);
    msg_t m;
    m.plane_id   = id;
    m.msg_type   = kind;
    m.msg_action = action;
    model_message(m);
    request_data  = m;
    request_valid = 1'b1;
    next_cycle();
    request_valid = 1'b0;
    repeat (REQUEST_GAP) next_cycle();
  endtask

  // Wait for all predicted replies, with a cycle limit
  task automatic drain();
    int cycles;
    cycles = 0;
    while (expected.size() != 0 && cycles < DRAIN_LIMIT) begin
      next_cycle();
      cycles++;
    end
    repeat (4) next_cycle();
  endtask

  task automatic check_runways();
    checks++;
    runway_check: assert (runway_active == model_active) else begin
      errors++;
      $display("Fail %0t: runway_active %b, expected %b", $time, runway_active, model_active);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reply monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    msg_t want;
    if (!reset && reply_send) begin
      if (expected.size() == 0) begin
        errors++;
        $display("Reply at %0t was not expected: id %0d type %0d action %b", $time,
                 reply_data.plane_id, reply_data.msg_type, reply_data.msg_action);
      end else begin
        want = expected.pop_front();
        checks++;
        reply_check: assert (reply_data == want) else begin
          errors++;
          $display("Fail %0t: reply id %0d type %0d action %b, expected id %0d type %0d action %b",
                   $time, reply_data.plane_id, reply_data.msg_type, reply_data.msg_action,
                   want.plane_id, want.msg_type, want.msg_action);
        end
      end
    end
    if (!reset && ready_blocked) begin
      blocked_check: assert (!reply_send) else begin
        errors++;
        $display("Fail %0t: reply sent while reply_ready was held low", $time);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * PERIOD_NS);
    $display("Timeout after %0d cycles with %0d replies outstanding", WATCHDOG_CYCLES,
             expected.size());
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int missing;
    void'($urandom(80449));
    request_data        = '0;
    request_valid       = 1'b0;
    reply_ready         = 1'b0;
    ready_mode          = READY_HIGH;
    ready_blocked       = 1'b0;
    checks              = 0;
    errors              = 0;
    model_taken         = '0;
    model_active        = '0;
    model_takeoff_first = 1'b0;
    wait (reset == 1'b0);
    next_cycle();

    // Untaken IDs are ignored, odd types get say again
    send_msg(4'd5, T_REQUEST, 1'b0);
    send_msg(4'd5, T_DECLARE, 1'b0);
    send_msg(4'd9, T_EMERGENCY, 1'b0);
    send_msg(4'd3, T_DIVERT, 1'b1);
    drain();

    // All sixteen IDs, then one too many
    ready_mode = READY_RANDOM;
    repeat (NUM_IDS + 1) send_msg(4'd0, T_ID_PLEASE, 1'b0);
    drain();

    // Two planes cleared, the third holds
    send_msg(4'd1, T_REQUEST, 1'b0);
    send_msg(4'd2, T_REQUEST, 1'b1);
    send_msg(4'd3, T_REQUEST, 1'b0);
    drain();
    check_runways();

    // Release by owner and non-owner, then alternation with both queues loaded
    send_msg(4'd2, T_DECLARE, 1'b0);
    drain();
    check_runways();
    send_msg(4'd1, T_DECLARE, 1'b0);
    send_msg(4'd4, T_REQUEST, 1'b1);
    send_msg(4'd5, T_REQUEST, 1'b1);
    send_msg(4'd6, T_REQUEST, 1'b0);
    send_msg(4'd7, T_REQUEST, 1'b0);
    send_msg(4'd3, T_DECLARE, 1'b0);
    send_msg(4'd2, T_DECLARE, 1'b1);
    send_msg(4'd4, T_DECLARE, 1'b0);
    send_msg(4'd6, T_DECLARE, 1'b1);
    drain();
    check_runways();

    // Fill the takeoff queue, the next plane is diverted and its ID reused
    ready_mode = READY_HIGH;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      send_msg(plane_id_t'(8 + i), T_REQUEST, 1'b0);
    end
    send_msg(4'd0, T_REQUEST, 1'b0);
    send_msg(4'd0, T_ID_PLEASE, 1'b0);
    drain();

    // Replies pile up while the output is blocked
    ready_mode = READY_LOW;
    repeat (2) next_cycle();
    ready_blocked = 1'b1;
    for (int i = 0; i < 6; i++) begin
      send_msg(plane_id_t'(1 + i), T_EMERGENCY, 1'b0);
    end
    ready_blocked = 1'b0;
    ready_mode    = READY_HIGH;
    drain();

    missing = expected.size();
    if (missing != 0) begin
      $display("%0d expected replies never arrived", missing);
    end
    $display("Checks: %0d, errors: %0d, missing replies: %0d", checks, errors, missing);
    if (errors == 0 && missing == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : atc_tb

// ==== testbench/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// Free-running clock and a synchronous reset held for a few cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2,
  parameter int DRIVE_DELAY  = 10
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // Reset drops just after an edge, like every other input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #(DRIVE_DELAY);
    reset = 1'b0;
  end

endmodule : tb_clock_gen

// ==== verilog/atc_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Tower controller definitions
// One-byte message format, message type codes, plane ID and runway sizes
////////////////////////////////////////////////////////////////////////////

package atc_pkg;

  // Plane identifier
  typedef logic [3:0] plane_id_t;

  // Request codes in the lower half, reply codes in the upper half
  typedef enum logic [2:0] {
    T_REQUEST   = 3'd0,
    T_DECLARE   = 3'd1,
    T_EMERGENCY = 3'd2,
    T_ID_PLEASE = 3'd3,
    T_HOLD      = 3'd4,
    T_CLEAR     = 3'd5,
    T_DIVERT    = 3'd6,
    T_SAY_AGAIN = 3'd7
  } msg_type_t;

  // Action bit
  //   request  takeoff (0) or landing (1)
  //   declare  runway number, also in a clear
  //   ID reply set when no ID was free
  typedef struct packed {
    plane_id_t plane_id;
    msg_type_t msg_type;
    logic      msg_action;
  } msg_t;

  localparam int NUM_IDS     = 2 ** $bits(plane_id_t);
  localparam int NUM_RUNWAYS = 2;

  // One runway lock
  typedef struct packed {
    plane_id_t owner;
    logic      active;
  } runway_t;

endpackage : atc_pkg

// ==== verilog/atc_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Airport tower controller
// Request buffer, request sequencer and reply sender
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module atc_top import atc_pkg::*; #(
  parameter int QUEUE_DEPTH = 8,
  parameter int MSG_DEPTH   = 4
) (
  input  logic                   clock,
  input  logic                   reset,
  input  msg_t                   request_data,
  input  logic                   request_valid,
  input  logic                   reply_ready,
  output msg_t                   reply_data,
  output logic                   reply_send,
  output logic [NUM_RUNWAYS-1:0] runway_active
);

  msg_t request_msg;
  logic request_empty;
  logic request_read;
  msg_t reply_msg;
  logic reply_write;
  logic reply_full;

  // Bytes arriving while full are dropped
  msg_fifo #(.payload_t(msg_t), .DEPTH(MSG_DEPTH)) request_buffer (
    .clock(clock), .reset(reset),
    .data_in(request_data), .write(request_valid), .read(request_read),
    .data_out(request_msg), .full(), .empty(request_empty)
  );

  request_sequencer #(.QUEUE_DEPTH(QUEUE_DEPTH)) sequencer (
    .clock(clock), .reset(reset),
    .request(request_msg), .request_empty(request_empty),
    .request_read(request_read),
    .reply_msg(reply_msg), .reply_write(reply_write), .reply_full(reply_full),
    .runway_active(runway_active)
  );

  reply_sender #(.MSG_DEPTH(MSG_DEPTH)) sender (
    .clock(clock), .reset(reset),
    .reply_msg(reply_msg), .reply_write(reply_write), .reply_full(reply_full),
    .reply_ready(reply_ready), .reply_data(reply_data), .reply_send(reply_send)
  );

endmodule : atc_top

// ==== verilog/id_pool.sv ====
////////////////////////////////////////////////////////////////////////////
// Plane ID pool
// One taken bit per ID, offers the lowest free ID
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module id_pool import atc_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  plane_id_t          release_id,
  input  logic               release_en,
  input  logic               take,
  output plane_id_t          free_id,
  output logic [NUM_IDS-1:0] taken,
  output logic               pool_full
);

  assign pool_full = &taken;

  // Priority search, lowest clear bit wins
  always_comb begin
    free_id = '0;
    for (int i = NUM_IDS - 1; i >= 0; i--) begin
      if (!taken[i]) free_id = plane_id_t'(i);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      taken <= '0;
    end else if (release_en) begin
      taken[release_id] <= 1'b0;
    end else if (take && !pool_full) begin
      taken[free_id] <= 1'b1;
    end
  end

endmodule : id_pool

// ==== verilog/msg_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// Message FIFO
// Circular buffer of any payload type, with a registered read port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module msg_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  payload_t data_in,
  input  logic     write,
  input  logic     read,
  output payload_t data_out,
  output logic     full,
  output logic     empty
);

  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  payload_t             mem [DEPTH];
  logic [PTR_W-1:0]     put_ptr;
  logic [PTR_W-1:0]     get_ptr;
  logic [COUNT_W-1:0]   count;
  logic                 do_read;
  logic                 do_write;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == COUNT_W'(DEPTH));

  // A pop frees a slot for a push in the same cycle
  assign do_read  = read && !empty;
  assign do_write = write && (!full || do_read);

  always_ff @(posedge clock) begin
    if (reset) begin
      put_ptr <= '0;
      get_ptr <= '0;
      count   <= '0;
    end else begin
      if (do_read) get_ptr <= next_ptr(get_ptr);
      if (do_write) put_ptr <= next_ptr(put_ptr);
      if (do_write && !do_read) count <= count + 1'b1;
      else if (do_read && !do_write) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (do_write) mem[put_ptr] <= data_in;
    if (do_read) data_out <= mem[get_ptr];
  end

endmodule : msg_fifo

// ==== verilog/reply_sender.sv ====
////////////////////////////////////////////////////////////////////////////
// Reply sender
// Buffers replies and hands them out one pulse at a time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reply_sender import atc_pkg::*; #(
  parameter int MSG_DEPTH = 4
) (
  input  logic clock,
  input  logic reset,
  input  msg_t reply_msg,
  input  logic reply_write,
  output logic reply_full,
  input  logic reply_ready,
  output msg_t reply_data,
  output logic reply_send
);

  typedef enum logic {
    WAIT,
    SEND
  } state_t;

  state_t state;
  logic   pop;
  logic   reply_empty;

  msg_fifo #(.payload_t(msg_t), .DEPTH(MSG_DEPTH)) reply_buffer (
    .clock(clock), .reset(reset),
    .data_in(reply_msg), .write(reply_write), .read(pop),
    .data_out(reply_data), .full(reply_full), .empty(reply_empty)
  );

  // Head lands in reply_data on the pop edge, pulse follows
  assign pop        = (state == WAIT) && reply_ready && !reply_empty;
  assign reply_send = (state == SEND);

  always_ff @(posedge clock) begin
    if (reset) state <= WAIT;
    else if (pop) state <= SEND;
    else state <= WAIT;
  end

endmodule : reply_sender

// ==== verilog/request_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Request sequencer
// Interprets requests, keeps the takeoff and landing queues and clears
// queued planes onto free runways
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module request_sequencer import atc_pkg::*; #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                   clock,
  input  logic                   reset,
  input  msg_t                   request,
  input  logic                   request_empty,
  output logic                   request_read,
  output msg_t                   reply_msg,
  output logic                   reply_write,
  input  logic                   reply_full,
  output logic [NUM_RUNWAYS-1:0] runway_active
);

  typedef enum logic [2:0] {
    IDLE,
    INTERPRET,
    REPLY,
    CHECK_QUEUES,
    CLEAR_TAKEOFF,
    CLEAR_LANDING,
    SEND_CLEAR
  } state_t;

  state_t             state;
  state_t             next_state;
  logic               push_takeoff;
  logic               push_landing;
  logic               pop_takeoff;
  logic               pop_landing;
  plane_id_t          takeoff_head;
  plane_id_t          landing_head;
  logic               takeoff_full;
  logic               takeoff_empty;
  logic               landing_full;
  logic               landing_empty;
  logic               take_plane;
  logic               release_plane;
  plane_id_t          free_id;
  logic [NUM_IDS-1:0] taken;
  logic               pool_full;
  logic               runway_sel;
  logic               lock;
  logic               unlock;
  plane_id_t          lock_id;
  runway_t            runway [NUM_RUNWAYS];
  logic               clear_runway;
  logic               owns_runway;
  logic               both_waiting;
  logic               start_clear;
  logic               takeoff_first;
  logic               toggle_order;
  logic               reply_load;
  msg_t               next_reply;

  ////////////////////////////////////////////////////////////////////////////
  // Queues, ID pool and runway locks
  ////////////////////////////////////////////////////////////////////////////

  msg_fifo #(.payload_t(plane_id_t), .DEPTH(QUEUE_DEPTH)) takeoff_queue (
    .clock(clock), .reset(reset),
    .data_in(request.plane_id), .write(push_takeoff), .read(pop_takeoff),
    .data_out(takeoff_head), .full(takeoff_full), .empty(takeoff_empty)
  );

  msg_fifo #(.payload_t(plane_id_t), .DEPTH(QUEUE_DEPTH)) landing_queue (
    .clock(clock), .reset(reset),
    .data_in(request.plane_id), .write(push_landing), .read(pop_landing),
    .data_out(landing_head), .full(landing_full), .empty(landing_empty)
  );

  id_pool ids (
    .clock(clock), .reset(reset),
    .release_id(request.plane_id), .release_en(release_plane), .take(take_plane),
    .free_id(free_id), .taken(taken), .pool_full(pool_full)
  );

  runway_locks locks (
    .clock(clock), .reset(reset),
    .runway_sel(runway_sel), .lock(lock), .lock_id(lock_id),
    .unlock(unlock), .unlock_id(request.plane_id),
    .runway(runway), .runway_active(runway_active)
  );

  // Lowest free runway for a clear
  assign clear_runway = runway_active[0];
  assign runway_sel   = (state == INTERPRET) ? request.msg_action : clear_runway;
  assign lock_id      = (state == CLEAR_TAKEOFF) ? takeoff_head : landing_head;
  assign owns_runway  = runway[request.msg_action].active &&
                        (runway[request.msg_action].owner == request.plane_id);
  assign both_waiting = !takeoff_empty && !landing_empty;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state    = state;
    request_read  = 1'b0;
    reply_write   = 1'b0;
    reply_load    = 1'b0;
    push_takeoff  = 1'b0;
    push_landing  = 1'b0;
    pop_takeoff   = 1'b0;
    pop_landing   = 1'b0;
    take_plane    = 1'b0;
    release_plane = 1'b0;
    lock          = 1'b0;
    unlock        = 1'b0;
    start_clear   = 1'b0;
    toggle_order  = 1'b0;
    // Most replies echo the sender's ID
    next_reply.plane_id   = request.plane_id;
    next_reply.msg_type   = T_SAY_AGAIN;
    next_reply.msg_action = 1'b0;

    case (state)
      IDLE: begin
        if (!request_empty) begin
          request_read = 1'b1;
          next_state   = INTERPRET;
        end else begin
          start_clear = 1'b1;
        end
      end

      INTERPRET: begin
        case (request.msg_type)
          T_REQUEST: begin
            if (!taken[request.plane_id]) begin
              next_state = CHECK_QUEUES;
            end else begin
              next_state = REPLY;
              reply_load = 1'b1;
              if (request.msg_action ? landing_full : takeoff_full) begin
                next_reply.msg_type = T_DIVERT;
                release_plane       = 1'b1;
              end else begin
                next_reply.msg_type = T_HOLD;
                push_takeoff        = !request.msg_action;
                push_landing        = request.msg_action;
              end
            end
          end
          T_DECLARE: begin
            next_state = CHECK_QUEUES;
            if (taken[request.plane_id]) begin
              unlock        = 1'b1;
              release_plane = owns_runway;
            end
          end
          T_ID_PLEASE: begin
            next_state          = REPLY;
            reply_load          = 1'b1;
            next_reply.msg_type = T_ID_PLEASE;
            if (pool_full) begin
              next_reply.plane_id   = '0;
              next_reply.msg_action = 1'b1;
            end else begin
              next_reply.plane_id = free_id;
              take_plane          = 1'b1;
            end
          end
          // Emergency and reply codes get say again
          default: begin
            next_state = REPLY;
            reply_load = 1'b1;
          end
        endcase
      end

      REPLY: begin
        if (!reply_full) begin
          reply_write = 1'b1;
          next_state  = CHECK_QUEUES;
        end
      end

      CHECK_QUEUES: start_clear = 1'b1;

      CLEAR_TAKEOFF, CLEAR_LANDING: begin
        lock                  = 1'b1;
        reply_load            = 1'b1;
        next_reply.plane_id   = lock_id;
        next_reply.msg_type   = T_CLEAR;
        next_reply.msg_action = clear_runway;
        next_state            = SEND_CLEAR;
      end

      SEND_CLEAR: begin
        if (!reply_full) begin
          reply_write = 1'b1;
          next_state  = IDLE;
        end
      end

      default: next_state = IDLE;
    endcase

    // Pop a queue when a runway is free, alternating when both wait
    if (start_clear) begin
      next_state = IDLE;
      if (runway_active != '1) begin
        if (both_waiting) begin
          toggle_order = 1'b1;
          pop_takeoff  = takeoff_first;
          pop_landing  = !takeoff_first;
        end else begin
          pop_takeoff = !takeoff_empty;
          pop_landing = !landing_empty;
        end
        if (pop_takeoff) next_state = CLEAR_TAKEOFF;
        else if (pop_landing) next_state = CLEAR_LANDING;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= IDLE;
      takeoff_first <= 1'b0;
    end else begin
      state <= next_state;
      if (toggle_order) takeoff_first <= !takeoff_first;
    end
  end

  always_ff @(posedge clock) begin
    if (reply_load) reply_msg <= next_reply;
  end

endmodule : request_sequencer

// ==== verilog/runway_locks.sv ====
////////////////////////////////////////////////////////////////////////////
// Runway locks
// Active bit and owning plane per runway, only the owner can unlock
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module runway_locks import atc_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   runway_sel,
  input  logic                   lock,
  input  plane_id_t              lock_id,
  input  logic                   unlock,
  input  plane_id_t              unlock_id,
  output runway_t                runway [NUM_RUNWAYS],
  output logic [NUM_RUNWAYS-1:0] runway_active
);

  always_comb begin
    for (int r = 0; r < NUM_RUNWAYS; r++) begin
      runway_active[r] = runway[r].active;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < NUM_RUNWAYS; r++) begin
        runway[r].active <= 1'b0;
      end
    end else if (lock) begin
      runway[runway_sel].owner  <= lock_id;
      runway[runway_sel].active <= 1'b1;
    end else if (unlock) begin
      // Someone else's declare leaves the lock in place
      if (runway[runway_sel].owner == unlock_id) begin
        runway[runway_sel].active <= 1'b0;
      end
    end
  end

endmodule : runway_locks
